//--- vlog.f
logic/overlay_pkg.sv
logic/sipo_in.sv
logic/pe_simd.sv
logic/piso_out.sv
logic/overlay.sv
sim/tb_clock.sv
sim/tb_overlay.sv

//--- Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_overlay
FILELIST := vlog.f

OBJ_DIR  := obj_dir
SIM      := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# fails unless the pass message shows up in the output
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf $(OBJ_DIR)

//--- sim/tb_overlay.sv
`timescale 1ns/1ps

module tb_overlay;

    localparam int pe_num     = 4;
    localparam int n_groups   = 200;
    localparam int period_ns  = 100;
    // cycle budget per group for the watchdog
    localparam int grp_cycles = 40;

    logic               clk;
    logic               rst_n;
    logic               din_v;
    overlay_pkg::word_t din;
    logic               inst_v;
    overlay_pkg::inst_t inst;
    logic               load;
    logic               ce;
    logic               dout_v;
    overlay_pkg::word_t dout;

    // model state
    overlay_pkg::inst_t cur_inst;
    overlay_pkg::word_t grp_exp [pe_num];
    overlay_pkg::word_t exp_q [$];
    int                 beats_seen;
    int                 val_errs;
    int                 proto_errs;

    tb_clock #(
        .period_ns  (period_ns),
        .rst_cycles (4)
    ) u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    overlay #(
        .pe_num (pe_num)
    ) u_dut (
        .clk    (clk),
        .rst_n  (rst_n),
        .din_v  (din_v),
        .din    (din),
        .inst_v (inst_v),
        .inst   (inst),
        .load   (load),
        .ce     (ce),
        .dout_v (dout_v),
        .dout   (dout)
    );

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    // 32 bit math, keep the low half for wrap-around
    function automatic overlay_pkg::lane_t calc_lane(
        input overlay_pkg::opcode_t op,
        input overlay_pkg::lane_t   a,
        input overlay_pkg::lane_t   b
    );
        int unsigned wide;
        wide = {16'd0, a};
        if (op == overlay_pkg::op_add) begin
            wide = {16'd0, a} + {16'd0, b};
        end else if (op == overlay_pkg::op_sub) begin
            wide = {16'd0, a} - {16'd0, b};
        end else if (op == overlay_pkg::op_mul) begin
            wide = {16'd0, a} * {16'd0, b};
        end else if (op == overlay_pkg::op_max && b > a) begin
            wide = {16'd0, b};
        end
        return wide[15:0];
    endfunction

    // lane 0 low, lane 1 high
    function automatic overlay_pkg::word_t calc_word(
        input overlay_pkg::inst_t ins,
        input overlay_pkg::word_t w
    );
        overlay_pkg::word_t r;
        if (ins.op == overlay_pkg::op_swap) begin
            r = {w[15:0], w[31:16]};
        end else begin
            r = {calc_lane(ins.op, w[31:16], ins.imm), calc_lane(ins.op, w[15:0], ins.imm)};
        end
        return r;
    endfunction

    task automatic check_val(
        input overlay_pkg::word_t got,
        input overlay_pkg::word_t want,
        input string              what
    );
        if (got !== want) begin
            $display("[FAIL] %0t ns: %s got %h, expected %h", $time, what, got, want);
            val_errs++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus tasks, each starts and ends just after a rising edge
    ////////////////////////////////////////////////////////////////////////////

    // random broadcast instruction, model switches with it
    task automatic issue_inst();
        overlay_pkg::inst_t ni;
        ni.op  = overlay_pkg::opcode_t'(3'($urandom % 6));
        ni.imm = overlay_pkg::lane_t'($urandom);
        inst_v <= 1'b1;
        inst   <= ni;
        @(posedge clk);
        inst_v <= 1'b0;
        cur_inst = ni;
    endtask

    // pe_num words with random idle gaps
    task automatic send_group();
        int                 gap;
        overlay_pkg::word_t w;
        for (int i = 0; i < pe_num; i++) begin
            gap = $urandom % 4;
            repeat (gap) begin
                din_v <= 1'b0;
                @(posedge clk);
            end
            w = $urandom;
            din_v <= 1'b1;
            din   <= w;
            // element i gets the i-th accepted word
            grp_exp[i] = calc_word(cur_inst, w);
            @(posedge clk);
        end
        din_v <= 1'b0;
    endtask

    // load pulse, then wait for all beats
    task automatic load_and_drain(input bit random_ce);
        int target;
        target = beats_seen + pe_num;
        for (int i = 0; i < pe_num; i++) begin
            exp_q.push_back(grp_exp[i]);
        end
        load <= 1'b1;
        @(posedge clk);
        load <= 1'b0;
        while (beats_seen < target) begin
            if (random_ce) begin
                // high about 60 percent of cycles
                ce <= ($urandom % 100) < 60;
            end else begin
                ce <= 1'b1;
            end
            @(posedge clk);
        end
        // ce left high so any extra beat shows up
        ce <= 1'b1;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // output monitor, mid cycle where dout is settled
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (rst_n && dout_v) begin
            if (exp_q.size() == 0) begin
                $display("error at %0t ns: output beat while no word was expected", $time);
                proto_errs++;
            end else begin
                check_val(dout, exp_q.pop_front(), "dout word");
            end
            beats_seen++;
        end
    end

    // watchdog
    initial begin
        #(n_groups * grp_cycles * period_ns);
        $display("timeout: run did not finish within %0d ns", n_groups * grp_cycles * period_ns);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        void'($urandom(38385));
        din_v  <= 1'b0;
        din    <= '0;
        inst_v <= 1'b0;
        inst   <= '0;
        load   <= 1'b0;
        ce     <= 1'b0;
        cur_inst = '{op: overlay_pkg::op_pass, imm: '0};
        beats_seen = 0;
        val_errs   = 0;
        proto_errs = 0;
        wait (rst_n);
        @(posedge clk);
        // idle with ce high, no beats allowed
        ce <= 1'b1;
        repeat (8) @(posedge clk);
        // load before any group gives the reset results
        for (int i = 0; i < pe_num; i++) begin
            grp_exp[i] = '0;
        end
        load_and_drain(1'b0);
        for (int g = 0; g < n_groups; g++) begin
            // early groups stay on reset pass
            if (g >= 8 && ($urandom % 3) == 0) begin
                issue_inst();
            end
            send_group();
            // results settle two edges after the last word
            repeat (2) @(posedge clk);
            load_and_drain(1'b1);
        end
        // trailing idle with ce high, any extra beat is caught
        repeat (10) @(posedge clk);
        $display("summary: %0d value errors, %0d other errors", val_errs, proto_errs);
        if (val_errs + proto_errs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- sim/tb_clock.sv
`timescale 1ns/1ps

// clock and reset source for the overlay testbench
module tb_clock #(
    parameter int period_ns  = 100,
    parameter int rst_cycles = 4
) (
    output logic clk,
    output logic rst_n
);

    // free running clock
    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // reset held low over the first rising edges, released on an edge
    initial begin
        rst_n = 1'b0;
        repeat (rst_cycles) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- logic/overlay.sv
`timescale 1ns/1ps

// simd overlay top
// deserializer, element row, serializer
module overlay #(
    parameter int pe_num = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 din_v,
    input  overlay_pkg::word_t   din,
    input  logic                 inst_v,
    input  overlay_pkg::inst_t   inst,
    input  logic                 load,
    input  logic                 ce,
    output logic                 dout_v,
    output overlay_pkg::word_t   dout
);

    // full group strobe from the deserializer
    logic                            grp_v;
    // one word per element, slot 0 is the first received
    overlay_pkg::word_t [pe_num-1:0] grp;
    // registered element results
    overlay_pkg::word_t [pe_num-1:0] res;

    //////////////////////////////////////////////////////////////////////////
    // input buffer
    //////////////////////////////////////////////////////////////////////////

    sipo_in #(
        .pe_num (pe_num)
    ) u_sipo (
        .clk   (clk),
        .rst_n (rst_n),
        .din_v (din_v),
        .din   (din),
        .grp_v (grp_v),
        .grp   (grp)
    );

    //////////////////////////////////////////////////////////////////////////
    // element row
    //////////////////////////////////////////////////////////////////////////

    // instruction is broadcast, each element gets its own slice
    for (genvar i = 0; i < pe_num; i++) begin : g_pe
        pe_simd u_pe (
            .clk    (clk),
            .rst_n  (rst_n),
            .grp_v  (grp_v),
            .din    (grp[i]),
            .inst_v (inst_v),
            .inst   (inst),
            .res    (res[i])
        );
    end

    //////////////////////////////////////////////////////////////////////////
    // output buffer
    //////////////////////////////////////////////////////////////////////////

    piso_out #(
        .pe_num (pe_num)
    ) u_piso (
        .clk    (clk),
        .rst_n  (rst_n),
        .load   (load),
        .ce     (ce),
        .res    (res),
        .dout_v (dout_v),
        .dout   (dout)
    );

endmodule

//--- logic/piso_out.sv
`timescale 1ns/1ps

// output serializer
// parallel capture on load, one word per ce cycle
module piso_out #(
    parameter int pe_num = 4
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                load,
    input  logic                                ce,
    input  overlay_pkg::word_t [pe_num-1:0]     res,
    output logic                                dout_v,
    output overlay_pkg::word_t                  dout
);

    // must hold the value pe_num itself
    localparam int cnt_w = $clog2(pe_num + 1);

    // captured results, element 0 first out
    overlay_pkg::word_t [pe_num-1:0] cap_q;
    // words still to send
    logic [cnt_w-1:0]                cnt_q;

    //////////////////////////////////////////////////////////////////////////
    // output side
    //////////////////////////////////////////////////////////////////////////

    // beat whenever ce is up and something is pending
    assign dout_v = ce && (cnt_q != '0);
    // head of the capture register
    assign dout   = cap_q[0];

    //////////////////////////////////////////////////////////////////////////
    // pending count
    //////////////////////////////////////////////////////////////////////////

    // load wins over a beat in the same cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt_q <= '0;
        end else if (load) begin
            cnt_q <= cnt_w'(pe_num);
        end else if (dout_v) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////////
    // capture and shift
    //////////////////////////////////////////////////////////////////////////

    // unsent words are simply overwritten by a new load
    // ce low holds everything in place
    always_ff @(posedge clk) begin
        if (load) begin
            cap_q <= res;
        end else if (dout_v) begin
            // next element moves into slot 0, zero fills the top
            cap_q <= {overlay_pkg::word_t'(0), cap_q[pe_num-1:1]};
        end
    end

    a_no_empty_beat: assert property (@(posedge clk) disable iff (!rst_n)
        dout_v |-> (cnt_q != '0))
        else $error("piso_out beat with nothing pending");

endmodule

//--- logic/pe_simd.sv
`timescale 1ns/1ps

// one simd processing element
// same instruction on both lanes of its word
module pe_simd (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 grp_v,
    input  overlay_pkg::word_t   din,
    input  logic                 inst_v,
    input  overlay_pkg::inst_t   inst,
    output overlay_pkg::word_t   res
);

    localparam int lw = overlay_pkg::lane_w;

    // current instruction
    overlay_pkg::inst_t inst_q;
    // lanes of the incoming slice
    overlay_pkg::lane_t lane0;
    overlay_pkg::lane_t lane1;
    // next result
    overlay_pkg::word_t res_d;

    //////////////////////////////////////////////////////////////////////////
    // lane arithmetic
    //////////////////////////////////////////////////////////////////////////

    // 16 bit context, so add, sub and mul all wrap
    function automatic overlay_pkg::lane_t lane_op(
        input overlay_pkg::opcode_t op,
        input overlay_pkg::lane_t   a,
        input overlay_pkg::lane_t   imm
    );
        overlay_pkg::lane_t r;
        case (op)
            overlay_pkg::op_add: r = a + imm;
            overlay_pkg::op_sub: r = a - imm;
            // low half of the product
            overlay_pkg::op_mul: r = a * imm;
            overlay_pkg::op_max: r = (a > imm) ? a : imm;
            // pass, swap handled at word level
            default:             r = a;
        endcase
        return r;
    endfunction

    assign lane0 = din[lw-1:0];
    assign lane1 = din[2*lw-1:lw];

    always_comb begin
        if (inst_q.op == overlay_pkg::op_swap) begin
            // lanes trade places, immediate unused
            res_d = {lane0, lane1};
        end else begin
            res_d = {lane_op(inst_q.op, lane1, inst_q.imm),
                     lane_op(inst_q.op, lane0, inst_q.imm)};
        end
    end

    //////////////////////////////////////////////////////////////////////////
    // registers
    //////////////////////////////////////////////////////////////////////////

    // instruction register, pass with zero immediate out of reset
    // a new instruction only hits groups strobed after it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            inst_q <= '{op: overlay_pkg::op_pass, imm: '0};
        end else if (inst_v) begin
            inst_q <= inst;
        end
    end

    // result register, zero until the first group
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res <= '0;
        end else if (grp_v) begin
            res <= res_d;
        end
    end

    a_op_legal: assert property (@(posedge clk) disable iff (!rst_n)
        inst_q.op inside {overlay_pkg::op_pass, overlay_pkg::op_add,
                          overlay_pkg::op_sub, overlay_pkg::op_mul,
                          overlay_pkg::op_max, overlay_pkg::op_swap})
        else $error("pe_simd holds an undefined opcode");

endmodule

//--- logic/sipo_in.sv
`timescale 1ns/1ps

// input deserializer
// gathers pe_num stream words into one parallel group
module sipo_in #(
    parameter int pe_num = 4
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                din_v,
    input  overlay_pkg::word_t                  din,
    output logic                                grp_v,
    output overlay_pkg::word_t [pe_num-1:0]     grp
);

    // one spare code so the count range can be checked
    localparam int cnt_w = $clog2(pe_num + 1);
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(pe_num - 1);

    // words accepted so far in the current group
    logic [cnt_w-1:0] cnt_q;
    // the word on din completes a group
    logic             last_word;

    assign last_word = din_v && (cnt_q == cnt_last);

    // word count and group strobe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt_q <= '0;
            grp_v <= 1'b0;
        end else begin
            // one cycle pulse after the final word
            grp_v <= last_word;
            if (last_word) begin
                cnt_q <= '0;
            end else if (din_v) begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    // new words enter at the top and walk down
    // after pe_num shifts the first word lands in slot 0
    always_ff @(posedge clk) begin
        if (din_v) begin
            grp <= {din, grp[pe_num-1:1]};
        end
    end

    // count wraps before it can reach pe_num
    a_cnt_range: assert property (@(posedge clk) disable iff (!rst_n)
        cnt_q < cnt_w'(pe_num))
        else $error("sipo_in count out of range");

endmodule

//--- logic/overlay_pkg.sv
package overlay_pkg;

    //////////////////////////////////////////////////////////////////////////
    // data widths
    //////////////////////////////////////////////////////////////////////////

    // one simd lane, unsigned, wraps on overflow
    localparam int lane_w = 16;
    // two lanes per stream word
    localparam int word_w = 2 * lane_w;

    typedef logic [lane_w-1:0] lane_t;

    // lane 0 sits in the low half
    typedef logic [word_w-1:0] word_t;

    //////////////////////////////////////////////////////////////////////////
    // instruction format
    //////////////////////////////////////////////////////////////////////////

    // element operations, codes 6 and 7 unused
    typedef enum logic [2:0] {
        op_pass = 3'd0,
        op_add  = 3'd1,
        op_sub  = 3'd2,
        op_mul  = 3'd3,
        op_max  = 3'd4,
        op_swap = 3'd5
    } opcode_t;

    // broadcast instruction, 19 bits
    // opcode in the top bits, immediate below
    typedef struct packed {
        opcode_t op;
        lane_t   imm;
    } inst_t;

endpackage
